// File: hdl/mem_host_defs.svh
/* Memory host sizes, reset fill value and scramble key
   Key rule is shared by the scrambler and the store reset fill */
`ifndef MEM_HOST_DEFS_SVH
`define MEM_HOST_DEFS_SVH

`define MH_MEM_WORDS    64
`define MH_CACHE_LINES  8

// Field widths of the byte address, must agree with the sizes above
`define MH_IDX_BITS     6
`define MH_LINE_BITS    3
`define MH_TAG_BITS     (`MH_IDX_BITS - `MH_LINE_BITS)

`define MH_FILL_BASE    32'hFEDC_BA98   // Word i reads back base + i
`define MH_SCRAMBLE_KEY 32'h5A3C_96E1

// Base key XOR word index repeated up to 32 bits, top bits dropped
`define MH_KEY(idx) \
    (`MH_SCRAMBLE_KEY ^ \
     32'({((32 + `MH_IDX_BITS - 1) / `MH_IDX_BITS){idx}}))

`endif

// File: hdl/wb_pkg.sv
/* Wishbone classic bus types for the memory host */
package wb_pkg;

    // Data bus, one 32-bit word
    typedef logic [31:0] wb_data_t;

    // Byte address as driven by the master
    typedef logic [31:0] wb_addr_t;

    // One select bit per data byte
    typedef logic [3:0] wb_sel_t;

endpackage

// File: hdl/mem_host_pkg.sv
/* Storage and address types of the memory host
   Byte address decoded as store word index or as cache tag and line */
`include "mem_host_defs.svh"

package mem_host_pkg;

    typedef logic [`MH_IDX_BITS-1:0]  word_idx_t;
    typedef logic [`MH_LINE_BITS-1:0] line_idx_t;
    typedef logic [`MH_TAG_BITS-1:0]  tag_t;

    // Store view of a byte address
    typedef struct packed {
        logic [31-`MH_IDX_BITS-2:0] unused;  // Ignored, addresses wrap
        word_idx_t                  idx;
        logic [1:0]                 ofs;
    } word_view_t;

    // Cache view of the same address
    typedef struct packed {
        logic [31-`MH_IDX_BITS-2:0] unused;
        tag_t                       tag;
        line_idx_t                  line;
        logic [1:0]                 ofs;
    } cache_view_t;

    typedef union packed {
        word_view_t  word;
        cache_view_t cache;
    } mem_addr_u;

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        ACCESS,
        COMPLETE
    } access_state_e;

endpackage

// File: hdl/data_scrambler.sv
/* Address-keyed XOR scrambler, same block scrambles and descrambles
   Each store word has its own key built from its index */
`timescale 1ns/1ps
`include "mem_host_defs.svh"

module data_scrambler
    import wb_pkg::*;
    import mem_host_pkg::*;
(
    input  word_idx_t word_idx,
    input  wb_data_t  din,
    output wb_data_t  dout
);

    wb_data_t key;

    // Key depends on the address only, so a stored word can always be undone
    assign key = `MH_KEY(word_idx);

    // Bitwise, so partial byte writes of scrambled data stay valid
    assign dout = din ^ key;

endmodule

// File: hdl/mem_array.sv
/* 64-word store with byte-enabled write and asynchronous read
   Reset loads every word with its fill value under its own key */
`timescale 1ns/1ps
`include "mem_host_defs.svh"

module mem_array
    import wb_pkg::*;
    import mem_host_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  word_idx_t word_idx,
    input  wb_sel_t   byte_en,
    input  wb_data_t  wdata,
    output wb_data_t  rdata
);

    wb_data_t mem [`MH_MEM_WORDS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Plain fill is base plus index, stored scrambled
            for (int i = 0; i < `MH_MEM_WORDS; i++) begin
                mem[i] <= (`MH_FILL_BASE + 32'(i)) ^ `MH_KEY(word_idx_t'(i));
            end
        end else if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata = mem[word_idx];   // Raw scrambled word

endmodule

// File: hdl/read_cache.sv
/* Direct-mapped read cache, 8 lines of one word with tag and valid
   Filled on read misses, byte-updated by writes that hit */
`timescale 1ns/1ps
`include "mem_host_defs.svh"

module read_cache
    import wb_pkg::*;
    import mem_host_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_idx_t word_idx,
    input  logic      fill,
    input  logic      wr,
    input  wb_data_t  fill_data,
    input  wb_data_t  wr_data,
    input  wb_sel_t   byte_en,
    output logic      hit,
    output wb_data_t  rdata
);

    wb_data_t                   line_data [`MH_CACHE_LINES];
    tag_t                       line_tag  [`MH_CACHE_LINES];
    logic [`MH_CACHE_LINES-1:0] line_valid;

    mem_addr_u lookup;
    line_idx_t line;
    tag_t      tag;

    // Rebuild a word-aligned address and read it through the cache view
    assign lookup = {{(32 - `MH_IDX_BITS - 2){1'b0}}, word_idx, 2'b00};
    assign line   = lookup.cache.line;
    assign tag    = lookup.cache.tag;

    assign hit   = line_valid[line] && (line_tag[line] == tag);
    assign rdata = line_data[line];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_valid <= '0;
        end else if (fill) begin
            line_valid[line] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            line_data[line] <= fill_data;   // Whole line replaced
            line_tag[line]  <= tag;
        end else if (wr && hit) begin
            // Write miss leaves the cache alone
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    line_data[line][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: hdl/mem_access_ctrl.sv
/* Wishbone classic slave FSM for the memory host
   Read hits ack after one edge, misses and writes go through decode and access */
`timescale 1ns/1ps

module mem_access_ctrl
    import wb_pkg::*;
    import mem_host_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  wb_addr_t  adr,
    input  wb_sel_t   sel,
    output wb_data_t  dat_r,
    output logic      ack,
    input  logic      cache_hit,
    input  wb_data_t  cache_data,
    input  wb_data_t  mem_rdata,
    output word_idx_t word_idx,
    output logic      mem_we,
    output wb_sel_t   byte_en,
    output logic      cache_fill,
    output logic      cache_wr
);

    mem_addr_u     addr_view;
    access_state_e state;
    logic          req;
    logic          rd_hit;

    assign addr_view = adr;
    assign word_idx  = addr_view.word.idx;   // High address bits ignored
    assign byte_en   = sel;

    assign req    = cyc && stb;
    assign rd_hit = (state == IDLE) && req && !we && cache_hit;

    // Store and cache act on the edge that leaves ACCESS
    assign mem_we     = (state == ACCESS) && req && we;
    assign cache_wr   = mem_we;
    assign cache_fill = (state == ACCESS) && req && !we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            ack <= 1'b0;   // Single-cycle pulse
            case (state)
                IDLE: begin
                    if (rd_hit) begin
                        state <= COMPLETE;
                        ack   <= 1'b1;
                    end else if (req) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    state <= req ? ACCESS : IDLE;   // Abandoned when stb drops
                end
                ACCESS: begin
                    if (req) begin
                        state <= COMPLETE;
                        ack   <= 1'b1;
                    end else begin
                        state <= IDLE;
                    end
                end
                COMPLETE: state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Read data from the cache on a hit, else the descrambled store word
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            dat_r <= cache_data;
        end else if (cache_fill) begin
            dat_r <= mem_rdata;
        end
    end

endmodule

// File: hdl/mem_host_top.sv
/* Memory host top, Wishbone slave over a scrambled 64-word store
   with a direct-mapped read cache in front */
`timescale 1ns/1ps

module mem_host_top
    import wb_pkg::*;
    import mem_host_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cyc,
    input  logic     stb,
    input  logic     we,
    input  wb_addr_t adr,
    input  wb_data_t dat_w,
    input  wb_sel_t  sel,
    output wb_data_t dat_r,
    output logic     ack
);

    word_idx_t word_idx;
    wb_sel_t   byte_en;
    logic      mem_we;
    logic      cache_fill;
    logic      cache_wr;
    logic      cache_hit;
    wb_data_t  cache_data;
    wb_data_t  mem_wdata;     // Scrambled
    wb_data_t  mem_raw;       // Scrambled, straight from the store
    wb_data_t  mem_rdata;     // Plain

    mem_access_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .sel        (sel),
        .dat_r      (dat_r),
        .ack        (ack),
        .cache_hit  (cache_hit),
        .cache_data (cache_data),
        .mem_rdata  (mem_rdata),
        .word_idx   (word_idx),
        .mem_we     (mem_we),
        .byte_en    (byte_en),
        .cache_fill (cache_fill),
        .cache_wr   (cache_wr)
    );

    // Cache holds plain data
    read_cache i_cache (
        .clk       (clk),
        .rst       (rst),
        .word_idx  (word_idx),
        .fill      (cache_fill),
        .wr        (cache_wr),
        .fill_data (mem_rdata),
        .wr_data   (dat_w),
        .byte_en   (byte_en),
        .hit       (cache_hit),
        .rdata     (cache_data)
    );

    data_scrambler i_scramble_wr (
        .word_idx (word_idx),
        .din      (dat_w),
        .dout     (mem_wdata)
    );

    mem_array i_mem (
        .clk      (clk),
        .rst      (rst),
        .we       (mem_we),
        .word_idx (word_idx),
        .byte_en  (byte_en),
        .wdata    (mem_wdata),
        .rdata    (mem_raw)
    );

    data_scrambler i_scramble_rd (
        .word_idx (word_idx),
        .din      (mem_raw),
        .dout     (mem_rdata)
    );

endmodule

// File: dv/mem_host_tests.svh
/* Directed tests for the memory host, with a plain-data model
   of the store and a model of the cache tags */
`ifndef MEM_HOST_TESTS_SVH
`define MEM_HOST_TESTS_SVH

wb_data_t                   model_mem   [`MH_MEM_WORDS];
logic [`MH_CACHE_LINES-1:0] model_valid;
int                         model_tag   [`MH_CACHE_LINES];
int                         test_start_errors;

// Byte address bits 7:2 pick the word, higher bits wrap
function automatic int word_of(input wb_addr_t a);
    return (a >> 2) % `MH_MEM_WORDS;
endfunction

function automatic logic model_hit(input int idx);
    int line;
    line = idx % `MH_CACHE_LINES;
    return model_valid[line] && (model_tag[line] == idx / `MH_CACHE_LINES);
endfunction

task automatic model_reset();
    for (int i = 0; i < `MH_MEM_WORDS; i++) begin
        model_mem[i] = `MH_FILL_BASE + i;
    end
    model_valid = '0;
endtask

task automatic model_write(input int idx, input wb_data_t d, input wb_sel_t s);
    for (int b = 0; b < 4; b++) begin
        if (s[b]) begin
            model_mem[idx][8*b +: 8] = d[8*b +: 8];
        end
    end
endtask

task automatic read_check(input wb_addr_t a);
    int       idx;
    int       exp_cycles;
    int       cycles;
    wb_data_t got;
    idx        = word_of(a);
    exp_cycles = model_hit(idx) ? 2 : 4;   // Hit acks after one edge, miss after three
    wb_read(a, got, cycles);
    check_latency($sformatf("read 0x%08h", a), cycles, exp_cycles);
    check_data($sformatf("read 0x%08h", a), got, model_mem[idx]);
    if (cycles != 0) begin
        model_valid[idx % `MH_CACHE_LINES] = 1'b1;   // Misses fill the line
        model_tag[idx % `MH_CACHE_LINES]   = idx / `MH_CACHE_LINES;
    end
endtask

task automatic write_update(input wb_addr_t a, input wb_data_t d, input wb_sel_t s);
    int cycles;
    wb_write(a, d, s, cycles);
    check_latency($sformatf("write 0x%08h", a), cycles, 4);
    if (cycles != 0) begin
        model_write(word_of(a), d, s);   // No allocate on write
    end
endtask

task automatic begin_test();
    test_start_errors = error_count;
endtask

task automatic end_test(input string name);
    int n;
    n = error_count - test_start_errors;
    tests_run++;
    if (n == 0) begin
        $display("PASS  %s", name);
    end else begin
        tests_failed++;
        $display("FAIL  %s, %0d errors", name, n);
    end
endtask

task automatic test_reset_fill();
    begin_test();
    for (int i = 0; i < `MH_MEM_WORDS; i++) begin
        read_check(wb_addr_t'(4 * i));
    end
    end_test("reset fill");
endtask

task automatic test_write_readback();
    wb_addr_t a;
    int       tries;
    begin_test();
    for (int n = 0; n < 8; n++) begin
        // High address bit forces an alias, pick a word not cached
        a     = ($urandom() & 32'hFFFF_FFFC) | 32'h100;
        tries = 0;
        while (model_hit(word_of(a)) && tries < 100) begin
            a = ($urandom() & 32'hFFFF_FFFC) | 32'h100;
            tries++;
        end
        write_update(a, $urandom(), 4'hF);
        read_check(a & 32'h0000_00FC);
    end
    end_test("write and read back");
endtask

task automatic test_byte_selects();
    wb_sel_t sels [4];
    begin_test();
    sels = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    for (int k = 0; k < 4; k++) begin
        write_update(wb_addr_t'(32'h60 + 4 * k), $urandom(), sels[k]);
        read_check(wb_addr_t'(32'h60 + 4 * k));
    end
    end_test("byte selects");
endtask

task automatic test_cache_hit();
    wb_addr_t a;
    begin_test();
    a = 32'h2C;
    read_check(a);
    read_check(a);                  // Now cached
    write_update(a, 32'hC0DE_0001, 4'hF);
    read_check(a);                  // Updated line still hits
    write_update(a, 32'h1234_5678, 4'b0011);
    read_check(a);
    end_test("cache hit and write update");
endtask

task automatic test_line_conflict();
    begin_test();
    // Words 21 and 53 share line 5 with tags 2 and 6
    read_check(32'hD4);
    for (int n = 0; n < 3; n++) begin
        read_check(32'h54);
        read_check(32'hD4);
    end
    end_test("line conflict");
endtask

task automatic test_abandon();
    begin_test();
    wb_abandon_write(32'h70, ~model_mem[word_of(32'h70)]);
    read_check(32'h70);   // Store must be untouched
    end_test("abandoned request");
endtask

`endif

// File: dv/mem_host_tb.sv
/* Memory host testbench with a Wishbone classic master, compare tasks
   and the directed test sequence */
`timescale 1ns/1ps
`include "mem_host_defs.svh"

module mem_host_tb
    import wb_pkg::*;
    import mem_host_pkg::*;
();

    localparam int ACK_TIMEOUT = 20;   // Cycles to wait for ack
    localparam int DRIVE_DLY   = 1;    // Inputs change this long after the edge

    logic     clk;
    logic     rst;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
    wb_sel_t  sel;
    wb_data_t dat_r;
    logic     ack;

    int error_count;
    int tests_run;
    int tests_failed;

    always #5 clk = ~clk;

    mem_host_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack)
    );

    task automatic check_data(input string what, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0d ns: %s returned 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        if (got != exp) begin
            error_count++;
            $display("[ERROR] %0d ns: %s took %0d cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic bus_release();
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = '0;
    endtask

    // Cycles of the transfer, 0 when no ack came
    task automatic wait_ack(input string what, output int cycles);
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < ACK_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DLY;
            edges++;
            seen = ack;
        end
        if (seen) begin
            cycles = edges + 1;   // Transfer closes on the edge that samples ack
        end else begin
            cycles = 0;
            error_count++;
            $display("The DUT gave no ack within %0d cycles on %s at %0d ns",
                     ACK_TIMEOUT, what, $time);
        end
    endtask

    task automatic wb_read(input wb_addr_t a, output wb_data_t data, output int cycles);
        @(posedge clk);
        #DRIVE_DLY;
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        sel = 4'hF;
        wait_ack($sformatf("read of 0x%08h", a), cycles);
        data = dat_r;
        bus_release();
    endtask

    task automatic wb_write(input wb_addr_t a, input wb_data_t d, input wb_sel_t s,
                            output int cycles);
        @(posedge clk);
        #DRIVE_DLY;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        sel   = s;
        wait_ack($sformatf("write of 0x%08h", a), cycles);
        bus_release();
    endtask

    // Starts a write, drops stb while the DUT decodes, then watches for a stray ack
    task automatic wb_abandon_write(input wb_addr_t a, input wb_data_t d);
        int   edges;
        logic seen;
        @(posedge clk);
        #DRIVE_DLY;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        sel   = 4'hF;
        @(posedge clk);
        #DRIVE_DLY;
        bus_release();
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < ACK_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DLY;
            edges++;
            seen = ack;
        end
        if (seen) begin
            error_count++;
            $display("The DUT acked an abandoned write to 0x%08h at %0d ns", a, $time);
        end
    endtask

    `include "mem_host_tests.svh"

    initial begin
        void'($urandom(32));
        clk          = 1'b0;
        rst          = 1'b1;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        bus_release();
        model_reset();
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        test_reset_fill();
        test_write_readback();
        test_byte_selects();
        test_cache_hit();
        test_line_conflict();
        test_abandon();

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+hdl
+incdir+dv
hdl/wb_pkg.sv
hdl/mem_host_pkg.sv
hdl/data_scrambler.sv
hdl/mem_array.sv
hdl/read_cache.sv
hdl/mem_access_ctrl.sv
hdl/mem_host_top.sv
dv/mem_host_tb.sv

// File: Bender.yml
package:
  name: mem_host

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wb_pkg.sv
      - hdl/mem_host_pkg.sv
      - hdl/data_scrambler.sv
      - hdl/mem_array.sv
      - hdl/read_cache.sv
      - hdl/mem_access_ctrl.sv
      - hdl/mem_host_top.sv
  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/mem_host_tb.sv
